/* Makefile */
# Verilator build and run of the instruction cache testbench
SIM      := verilator
TOP      := tb_icache
FILELIST := verilog.f
BUILD    := obj_dir
FLAGS    := --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# Output goes to the terminal and the pass line decides the status
run: compile
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q '^NO ERRORS$$'

clean:
	rm -rf $(BUILD)

/* icache_ctl_pkg.sv */
/*
 * Control encodings for the cache: the fill controller states and the
 * opcode carried on the invalidate port.
 */

package icache_ctl_pkg;

	// Controller states, one request in flight at a time
	typedef enum logic [2:0] {
		s_idle,
		s_lookup,
		s_fetch_ack,
		s_mem_req,
		s_mem_wait_low,
		s_write,
		s_inv,
		s_inv_ack
	} fill_state_t;

	// Clear one set in all ways, or clear every set
	typedef enum logic {
		inv_line = 1'b0,
		inv_all = 1'b1
	} inv_op_t;

endpackage

/* icache_data.sv */
/*
 * Line store of the instruction cache, one line array per way.
 * A fill writes a whole line; the read side picks the line by way and
 * set and returns one 32-bit word from it.
 */

module icache_data
	import icache_pkg::*;
(
	input logic clk,
	input logic fill_wr,
	input way_t fill_way,
	input index_t fill_index,
	input line_t fill_line,
	input index_t rd_index,
	input way_t rd_way,
	input logic [1:0] rd_word_sel,
	output word_t data
);

	// ============================================================
	// Line arrays
	// ============================================================

	line_t line_q [ways][sets];
	line_t rd_line;

	// Written only by the fill controller, once per miss
	always_ff @(posedge clk) begin
		if (fill_wr) begin
			line_q[fill_way][fill_index] <= fill_line;
		end
	end

	// ============================================================
	// Read side
	// ============================================================

	// Line select from the registered index and the registered hit way
	assign rd_line = line_q[rd_way][rd_index];

	// Word k of the line occupies bits k*32 up to k*32+31
	assign data = rd_line[rd_word_sel*word_w +: word_w];

endmodule

/* icache_fill.sv */
/*
 * Control FSM of the instruction cache. It serves the fetch and the
 * invalidate ports one request at a time, runs the four-phase memory
 * handshake on a miss and writes the returned line into the stores.
 */

module icache_fill
	import icache_pkg::*, icache_ctl_pkg::*;
(
	input logic clk,
	input logic rst,
	// Fetch and invalidate ports
	input logic req,
	input addr_t adr,
	output logic ack,
	input logic inv_req,
	input inv_op_t inv_op_in,
	input addr_t inv_adr,
	output logic inv_ack,
	// Memory port
	output logic mem_req,
	output addr_t mem_adr,
	input logic mem_ack,
	input line_t mem_line,
	// Lookup
	input logic hit,
	input way_t hit_way,
	input way_t victim_way,
	output index_t rd_index,
	output tag_t rd_tag,
	output logic [1:0] rd_word_sel,
	output way_t rd_way,
	// Store updates
	output logic fill_wr,
	output way_t fill_way,
	output index_t fill_index,
	output tag_t fill_tag,
	output line_t fill_line,
	output logic inv_en,
	output inv_op_t inv_op,
	output index_t inv_index
);

	fill_state_t state;
	addr_t adr_q;

	// ============================================================
	// Control state
	// ============================================================

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= s_idle;
			ack <= 1'b0;
			inv_ack <= 1'b0;
			mem_req <= 1'b0;
		end else begin
			case (state)
				// A fetch wins over a pending invalidate
				s_idle: begin
					if (req) begin
						state <= s_lookup;
					end else if (inv_req) begin
						state <= s_inv;
					end
				end
				// Stores are read from adr_q during this cycle
				s_lookup: begin
					if (hit) begin
						ack <= 1'b1;
						state <= s_fetch_ack;
					end else begin
						mem_req <= 1'b1;
						state <= s_mem_req;
					end
				end
				// Hold ack until the core lets go of req
				s_fetch_ack: begin
					if (!req) begin
						ack <= 1'b0;
						state <= s_idle;
					end
				end
				s_mem_req: begin
					if (mem_ack) begin
						mem_req <= 1'b0;
						state <= s_mem_wait_low;
					end
				end
				// The memory must finish its phase before the line is written
				s_mem_wait_low: begin
					if (!mem_ack) begin
						state <= s_write;
					end
				end
				// After the write the lookup repeats and now hits
				s_write: state <= s_lookup;
				s_inv: begin
					inv_ack <= 1'b1;
					state <= s_inv_ack;
				end
				s_inv_ack: begin
					if (!inv_req) begin
						inv_ack <= 1'b0;
						state <= s_idle;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// ============================================================
	// Request and fill payload
	// ============================================================

	always_ff @(posedge clk) begin
		if (state == s_idle && req) begin
			adr_q <= adr;
		end
		if (state == s_idle && !req && inv_req) begin
			inv_op <= inv_op_in;
			inv_index <= inv_adr[offset_w +: index_w];
		end
		// Hit way feeds the data read, victim way the coming fill
		if (state == s_lookup) begin
			rd_way <= hit_way;
			fill_way <= victim_way;
		end
		if (state == s_mem_req && mem_ack) begin
			fill_line <= mem_line;
		end
	end

	// Address fields of the request being served
	assign rd_index = adr_q[offset_w +: index_w];
	assign rd_tag = adr_q[addr_w-1 -: tag_w];
	assign rd_word_sel = adr_q[offset_w-1 -: 2];
	assign fill_index = rd_index;
	assign fill_tag = rd_tag;

	// Memory always transfers whole lines
	assign mem_adr = {adr_q[addr_w-1:offset_w], {offset_w{1'b0}}};

	// One-cycle strobes straight from the state
	assign fill_wr = (state == s_write);
	assign inv_en = (state == s_inv);

	// A new memory request must wait for the previous ack to fall
	a_mem_req_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(mem_req) |-> !mem_ack);

endmodule

/* icache_pkg.sv */
/*
 * Geometry of the instruction cache and the address, line and word types
 * shared by the stores, the fill controller and the top level.
 * Import with a wildcard in the module header where needed.
 */

package icache_pkg;

	// ============================================================
	// Geometry
	// ============================================================

	// Byte address into the 64 KiB code space
	localparam int addr_w = 16;

	// Four ways of sixteen sets, each line holds four words
	localparam int ways = 4;
	localparam int sets = 16;

	// Address fields, from the bottom up: offset, index, tag
	localparam int offset_w = 4;
	localparam int index_w = 4;
	localparam int tag_w = 8;

	// Word 0 of a line sits in the low 32 bits of the line
	localparam int word_w = 32;
	localparam int line_w = 128;
	localparam int way_w = 2;

	// ============================================================
	// Types
	// ============================================================

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [index_w-1:0] index_t;
	typedef logic [tag_w-1:0] tag_t;
	typedef logic [way_w-1:0] way_t;
	typedef logic [line_w-1:0] line_t;
	typedef logic [word_w-1:0] word_t;

endpackage

/* icache_tags.sv */
/*
 * Tag store of the instruction cache with the hit compare across all ways.
 * It also keeps a round-robin pointer per set and picks the victim way
 * for the next fill: lowest invalid way first, else the pointer.
 */

module icache_tags
	import icache_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic fill_wr,
	input way_t fill_way,
	input index_t fill_index,
	input tag_t fill_tag,
	input index_t rd_index,
	input tag_t rd_tag,
	input logic [ways-1:0] valid,
	output logic hit,
	output way_t hit_way,
	output way_t victim_way
);

	tag_t tag_q [ways][sets];
	way_t rr_q [sets];
	logic [ways-1:0] match;

	// ============================================================
	// Storage
	// ============================================================

	// Tags are payload, only a valid bit makes them meaningful
	always_ff @(posedge clk) begin
		if (fill_wr) begin
			tag_q[fill_way][fill_index] <= fill_tag;
		end
	end

	// The pointer of a set steps on every fill into that set
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int s = 0; s < sets; s++) begin
				rr_q[s] <= '0;
			end
		end else if (fill_wr) begin
			rr_q[fill_index] <= rr_q[fill_index] + 1'b1;
		end
	end

	// ============================================================
	// Lookup
	// ============================================================

	// Only a valid way can hit
	always_comb begin
		for (int w = 0; w < ways; w++) begin
			match[w] = valid[w] && (tag_q[w][rd_index] == rd_tag);
		end
	end

	assign hit = |match;

	// Walk downwards so the lowest matching way is kept
	always_comb begin
		hit_way = '0;
		for (int w = ways - 1; w >= 0; w--) begin
			if (match[w]) begin
				hit_way = way_t'(w);
			end
		end
	end

	// Prefer the lowest empty way; with a full set fall back to the pointer
	always_comb begin
		victim_way = rr_q[rd_index];
		for (int w = ways - 1; w >= 0; w--) begin
			if (!valid[w]) begin
				victim_way = way_t'(w);
			end
		end
	end

	// A line is only ever filled after a miss, so a tag lives in one way
	a_onehot_hit: assert property (@(posedge clk) disable iff (rst)
		$onehot0(match));

endmodule

/* icache_top.sv */
/*
 * Top level of the instruction cache. It ties the fill controller to the
 * valid, tag and data stores and brings out the fetch, invalidate and
 * memory ports.
 */

module icache_top
	import icache_pkg::*, icache_ctl_pkg::*;
(
	input logic clk,
	input logic rst,
	// Fetch port
	input logic req,
	input addr_t adr,
	output logic ack,
	output word_t data,
	// Invalidate port
	input logic inv_req,
	input inv_op_t inv_op,
	input addr_t inv_adr,
	output logic inv_ack,
	// Memory port
	output logic mem_req,
	output addr_t mem_adr,
	input logic mem_ack,
	input line_t mem_line
);

	// ============================================================
	// Internal nets
	// ============================================================

	// Lookup side
	index_t rd_index;
	tag_t rd_tag;
	logic [1:0] rd_word_sel;
	way_t rd_way;
	logic [ways-1:0] valid;
	logic hit;
	way_t hit_way;
	way_t victim_way;

	// Store updates
	logic fill_wr;
	way_t fill_way;
	index_t fill_index;
	tag_t fill_tag;
	line_t fill_line;
	logic inv_en;
	inv_op_t cur_inv_op;
	index_t inv_index;

	icache_fill icache_fill_i (
		.clk(clk), .rst(rst),
		.req(req), .adr(adr), .ack(ack),
		.inv_req(inv_req), .inv_op_in(inv_op), .inv_adr(inv_adr), .inv_ack(inv_ack),
		.mem_req(mem_req), .mem_adr(mem_adr), .mem_ack(mem_ack), .mem_line(mem_line),
		.hit(hit), .hit_way(hit_way), .victim_way(victim_way),
		.rd_index(rd_index), .rd_tag(rd_tag), .rd_word_sel(rd_word_sel), .rd_way(rd_way),
		.fill_wr(fill_wr), .fill_way(fill_way), .fill_index(fill_index),
		.fill_tag(fill_tag), .fill_line(fill_line),
		.inv_en(inv_en), .inv_op(cur_inv_op), .inv_index(inv_index)
	);

	icache_valid icache_valid_i (
		.clk(clk), .rst(rst),
		.fill_wr(fill_wr), .fill_way(fill_way), .fill_index(fill_index),
		.inv_en(inv_en), .inv_op(cur_inv_op), .inv_index(inv_index),
		.rd_index(rd_index), .valid(valid)
	);

	icache_tags icache_tags_i (
		.clk(clk), .rst(rst),
		.fill_wr(fill_wr), .fill_way(fill_way), .fill_index(fill_index),
		.fill_tag(fill_tag), .rd_index(rd_index), .rd_tag(rd_tag), .valid(valid),
		.hit(hit), .hit_way(hit_way), .victim_way(victim_way)
	);

	// Data word is meaningful only while ack is high
	icache_data icache_data_i (
		.clk(clk),
		.fill_wr(fill_wr), .fill_way(fill_way), .fill_index(fill_index),
		.fill_line(fill_line), .rd_index(rd_index), .rd_way(rd_way),
		.rd_word_sel(rd_word_sel), .data(data)
	);

endmodule

/* icache_valid.sv */
/*
 * Valid-bit array of the instruction cache, one bit per way and set.
 * A fill sets one bit, an invalidate clears a set or the whole array.
 * The read side gives the bits of all ways for the looked-up set.
 */

module icache_valid
	import icache_pkg::*, icache_ctl_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic fill_wr,
	input way_t fill_way,
	input index_t fill_index,
	input logic inv_en,
	input inv_op_t inv_op,
	input index_t inv_index,
	input index_t rd_index,
	output logic [ways-1:0] valid
);

	// One word per set, one bit per way
	logic [ways-1:0] vbits [sets];

	// ============================================================
	// Update
	// ============================================================

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int s = 0; s < sets; s++) begin
				vbits[s] <= '0;
			end
		end else if (fill_wr) begin
			// A fill wins over an invalidate in the same cycle
			vbits[fill_index][fill_way] <= 1'b1;
		end else if (inv_en) begin
			if (inv_op == inv_all) begin
				for (int s = 0; s < sets; s++) begin
					vbits[s] <= '0;
				end
			end else begin
				vbits[inv_index] <= '0;
			end
		end
	end

	// Read is combinational from the controller's registered index
	assign valid = vbits[rd_index];

	// The controller sequences fills and invalidates in separate states,
	// so the two strobes must never meet here
	a_no_fill_inv: assert property (@(posedge clk) disable iff (rst)
		!(fill_wr && inv_en));

endmodule

/* tb_icache.sv */
/*
 * Testbench top for the instruction cache. It drives random fetches and
 * invalidates from a fixed seed, answers the memory port with a known
 * line pattern and prints the verdict from the checker's counts.
 */

module tb_icache
	import icache_pkg::*, icache_ctl_pkg::*;
();

	localparam int n_fetch = 400;
	localparam int half_period = 50;
	// Average cycle budget per request over the whole run
	localparam int cycles_per_req = 40;

	logic clk = 1'b0;
	logic rst;
	logic req;
	addr_t adr;
	logic ack;
	word_t data;
	logic inv_req;
	inv_op_t inv_op;
	addr_t inv_adr;
	logic inv_ack;
	logic mem_req;
	addr_t mem_adr;
	logic mem_ack;
	line_t mem_line;

	int seed = 35470;
	int n_inv;
	int errors;
	int hits;
	int misses;

	always #half_period clk = ~clk;

	icache_top icache_top_i (
		.clk(clk), .rst(rst),
		.req(req), .adr(adr), .ack(ack), .data(data),
		.inv_req(inv_req), .inv_op(inv_op), .inv_adr(inv_adr), .inv_ack(inv_ack),
		.mem_req(mem_req), .mem_adr(mem_adr), .mem_ack(mem_ack), .mem_line(mem_line)
	);

	tb_icache_checker checker_i (
		.clk(clk), .rst(rst),
		.req(req), .adr(adr), .ack(ack), .data(data),
		.inv_req(inv_req), .inv_op(inv_op), .inv_adr(inv_adr), .inv_ack(inv_ack),
		.mem_req(mem_req), .mem_adr(mem_adr), .mem_ack(mem_ack),
		.errors(errors), .hits(hits), .misses(misses)
	);

	// ============================================================
	// Random helpers
	// ============================================================

	// Uniform draw from 0 up to n-1
	function automatic int pick(int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	// Word k of the line mixes the line address with k
	function automatic line_t line_for(addr_t a);
		line_t l;
		addr_t base;
		base = {a[addr_w-1:offset_w], {offset_w{1'b0}}};
		for (int k = 0; k < 4; k++) begin
			l[k*word_w +: word_w] = {base, base ^ 16'h5a3c} ^ (32'h0101_0101 * (k + 1));
		end
		return l;
	endfunction

	// Eight tags share two sets in 256 bytes of code
	// so that reuse and eviction both happen often
	function automatic addr_t window_addr();
		tag_t t;
		index_t s;
		t = tag_t'(pick(8));
		s = (pick(2) == 0) ? index_t'(2) : index_t'(9);
		return {t, s, 4'(pick(16))};
	endfunction

	// ============================================================
	// Requests
	// ============================================================

	// Four-phase fetch that holds req a random while after ack
	task automatic fetch(addr_t a);
		@(posedge clk);
		#1;
		req = 1'b1;
		adr = a;
		@(posedge clk);
		while (!ack) @(posedge clk);
		repeat (pick(6)) @(posedge clk);
		#1;
		req = 1'b0;
		@(posedge clk);
		while (ack) @(posedge clk);
	endtask

	task automatic invalidate(inv_op_t op, addr_t a);
		n_inv++;
		@(posedge clk);
		#1;
		inv_req = 1'b1;
		inv_op = op;
		inv_adr = a;
		@(posedge clk);
		while (!inv_ack) @(posedge clk);
		repeat (pick(6)) @(posedge clk);
		#1;
		inv_req = 1'b0;
		@(posedge clk);
		while (inv_ack) @(posedge clk);
	endtask

	// Memory side answers each line request after 1 to 8 cycles
	// and keeps mem_ack high for a random while after mem_req falls
	initial begin : memory
		int delay;
		mem_ack = 1'b0;
		mem_line = '0;
		forever begin
			@(posedge clk);
			if (mem_req && !mem_ack) begin
				delay = 1 + pick(8);
				repeat (delay - 1) @(posedge clk);
				#1;
				mem_line = line_for(mem_adr);
				mem_ack = 1'b1;
				@(posedge clk);
				while (mem_req) @(posedge clk);
				repeat (pick(16)) @(posedge clk);
				#1;
				mem_ack = 1'b0;
			end
		end
	end

	initial begin : watchdog
		#((n_fetch * cycles_per_req + 20) * 2 * half_period);
		$display("Timeout: the cache stopped answering before all requests were done");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		int r;
		rst = 1'b1;
		req = 1'b0;
		adr = '0;
		inv_req = 1'b0;
		inv_op = inv_line;
		inv_adr = '0;
		n_inv = 0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		// The outputs must stay low through a few quiet cycles first
		repeat (5) @(posedge clk);
		for (int i = 0; i < n_fetch; i++) begin
			r = pick(32);
			if (r == 0) begin
				invalidate(inv_all, '0);
			end else if (r < 4) begin
				invalidate(inv_line, window_addr());
			end
			fetch(window_addr());
		end
		repeat (4) @(posedge clk);
		$display("Fetches %0d, hits %0d, misses %0d, invalidates %0d, errors %0d",
			n_fetch, hits, misses, n_inv, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* tb_icache_checker.sv */
/*
 * Checker for the instruction cache testbench. It samples the ports on
 * every rising edge, keeps a reference model of valid bits, tags and
 * round-robin pointers, and compares data, miss traffic and handshakes.
 */

module tb_icache_checker
	import icache_pkg::*, icache_ctl_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req,
	input addr_t adr,
	input logic ack,
	input word_t data,
	input logic inv_req,
	input inv_op_t inv_op,
	input addr_t inv_adr,
	input logic inv_ack,
	input logic mem_req,
	input addr_t mem_adr,
	input logic mem_ack,
	output int errors,
	output int hits,
	output int misses
);

	// Reference state of the cache
	logic m_valid [sets][ways];
	tag_t m_tag [sets][ways];
	way_t m_rr [sets];

	// Port values seen at the previous edge
	logic p_req;
	logic p_ack;
	logic p_inv_req;
	logic p_inv_ack;
	logic p_mem_req;
	logic p_mem_ack;

	// The fetch currently in flight
	logic open_fetch;
	logic predict_hit;
	logic seen_request;
	addr_t fetch_adr;
	int latency;
	int mem_reqs;

	// ============================================================
	// Reference rules
	// ============================================================

	// Word k of a line mixes the line address with k
	function automatic word_t expected_word(addr_t a);
		addr_t base;
		int k;
		base = {a[addr_w-1:offset_w], {offset_w{1'b0}}};
		k = int'(a[3:2]);
		return {base, base ^ 16'h5a3c} ^ (32'h0101_0101 * (k + 1));
	endfunction

	function automatic logic model_hit(addr_t a);
		index_t s;
		logic found;
		s = a[offset_w +: index_w];
		found = 1'b0;
		for (int w = 0; w < ways; w++) begin
			if (m_valid[s][w] && m_tag[s][w] == a[addr_w-1 -: tag_w]) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	// Lowest empty way of the set, or its pointer once the set is full
	task automatic model_fill(addr_t a);
		index_t s;
		way_t v;
		logic found;
		s = a[offset_w +: index_w];
		v = m_rr[s];
		found = 1'b0;
		for (int w = 0; w < ways; w++) begin
			if (!found && !m_valid[s][w]) begin
				v = way_t'(w);
				found = 1'b1;
			end
		end
		m_valid[s][v] = 1'b1;
		m_tag[s][v] = a[addr_w-1 -: tag_w];
		m_rr[s] = m_rr[s] + 2'd1;
	endtask

	task automatic model_invalidate(inv_op_t op, addr_t a);
		for (int s = 0; s < sets; s++) begin
			for (int w = 0; w < ways; w++) begin
				if (op == inv_all || index_t'(s) == a[offset_w +: index_w]) begin
					m_valid[s][w] = 1'b0;
				end
			end
		end
	endtask

	task automatic report_error(string msg);
		$display("Error at time %0t: %s", $time, msg);
		errors++;
	endtask

	// ============================================================
	// Monitor
	// ============================================================

	always @(posedge clk) begin
		if (rst) begin
			model_invalidate(inv_all, '0);
			for (int s = 0; s < sets; s++) begin
				m_rr[s] = '0;
			end
			p_req = 1'b0;
			p_ack = 1'b0;
			p_inv_req = 1'b0;
			p_inv_ack = 1'b0;
			p_mem_req = 1'b0;
			p_mem_ack = 1'b0;
			open_fetch = 1'b0;
			seen_request = 1'b0;
			errors = 0;
			hits = 0;
			misses = 0;
		end else begin
			// Out of reset every handshake output stays quiet
			if (!seen_request && (ack || inv_ack || mem_req)) begin
				report_error("handshake output high before any request");
			end
			if (req || inv_req) begin
				seen_request = 1'b1;
			end
			if (open_fetch) begin
				latency++;
			end
			// A new fetch, judged against the model before the cache answers
			if (req && !p_req) begin
				open_fetch = 1'b1;
				fetch_adr = adr;
				latency = 0;
				mem_reqs = 0;
				predict_hit = model_hit(adr);
			end
			if (mem_req && !p_mem_req) begin
				mem_reqs++;
				if (!open_fetch) begin
					report_error("mem_req raised with no fetch in flight");
				end
				if (mem_adr != {fetch_adr[addr_w-1:offset_w], {offset_w{1'b0}}}) begin
					report_error($sformatf("mem_adr %h for fetch %h", mem_adr, fetch_adr));
				end
				if (mem_ack) begin
					report_error("mem_req raised while mem_ack still high");
				end
			end
			if (!mem_req && p_mem_req && !p_mem_ack) begin
				report_error("mem_req dropped before mem_ack rose");
			end
			if (ack && !p_ack) begin
				if (!open_fetch) begin
					report_error("ack raised with no fetch in flight");
				end
				if (data !== expected_word(fetch_adr)) begin
					report_error($sformatf("adr %h data %h expected %h",
						fetch_adr, data, expected_word(fetch_adr)));
				end
				if (predict_hit) begin
					hits++;
					if (mem_reqs != 0) begin
						report_error($sformatf("predicted hit at %h went to memory", fetch_adr));
					end
					if (latency != 2) begin
						report_error($sformatf("hit latency %0d, expected 2", latency));
					end
				end else begin
					misses++;
					if (mem_reqs != 1) begin
						report_error($sformatf("miss at %h made %0d memory requests",
							fetch_adr, mem_reqs));
					end
					model_fill(fetch_adr);
				end
				open_fetch = 1'b0;
			end
			if (!ack && p_ack && p_req) begin
				report_error("ack dropped while req still high");
			end
			// The invalidate takes effect by the time inv_ack rises
			if (inv_ack && !p_inv_ack) begin
				model_invalidate(inv_op, inv_adr);
			end
			if (!inv_ack && p_inv_ack && p_inv_req) begin
				report_error("inv_ack dropped while inv_req still high");
			end
			p_req = req;
			p_ack = ack;
			p_inv_req = inv_req;
			p_inv_ack = inv_ack;
			p_mem_req = mem_req;
			p_mem_ack = mem_ack;
		end
	end

endmodule

/* verilog.f */
icache_pkg.sv
icache_ctl_pkg.sv
icache_valid.sv
icache_tags.sv
icache_data.sv
icache_fill.sv
icache_top.sv
tb_icache_checker.sv
tb_icache.sv
